/* flist.f */
+incdir+src
src/isa_pkg.sv
src/trace_pkg.sv
src/instr_fetch.sv
src/instr_decode.sv
src/exec_mem_wb.sv
src/pipeline_tracker.sv
src/pipe_top.sv
testbench/pipe_tb.sv

/* testbench/pipe_tb.sv */
`timescale 1ns/1ns

`include "pipe_config.svh"

module pipe_tb;
    import isa_pkg::*;
    import trace_pkg::*;

    logic        clk;
    logic        rst;
    logic        run;
    logic        imem_we;
    pc_t         imem_addr;
    instr_t      imem_wdata;
    logic        retire_valid;
    retire_rec_t retire;
    logic        done;

    // Program under test and the architectural model that predicts it
    instr_t      prog [`PIPE_IMEM_DEPTH];
    int          prog_len;
    xword_t      ref_regs [`PIPE_NREGS];
    xword_t      ref_dmem [`PIPE_DMEM_DEPTH];
    tag_t        next_tag;
    retire_rec_t exp_q [$];
    logic        halt_q [$];
    retire_rec_t exp_rec;
    logic        exp_halt;
    int          done_cnt = 0;
    integer      seed;

    pipe_top DUT (
        .clk          (clk),
        .rst          (rst),
        .run          (run),
        .imem_we      (imem_we),
        .imem_addr    (imem_addr),
        .imem_wdata   (imem_wdata),
        .retire_valid (retire_valid),
        .retire       (retire),
        .done         (done)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic stop_run();
        $display("Some tests failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic report_error(input string what);
        $display("%s at time %0t", what, $time);
        stop_run();
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] want);
        $display("error: %s got 0x%0h expected 0x%0h", name, got, want);
        stop_run();
    endtask

    // True when the instruction takes r as a source operand
    function automatic logic reads_reg(input instr_t w, input reg_idx_t r);
        case (w.opcode)
            ADD, SUB, STORE: return w.rs1 == r || w.field[2:0] == r;
            ADDI, LOAD:      return w.rs1 == r;
            default:         return 1'b0;
        endcase
    endfunction

    // Executes the program in order and queues one expected record per instruction
    function automatic void predict();
        int          stalls [`PIPE_IMEM_DEPTH];
        int          i;
        int          addr;
        instr_t      w;
        xword_t      a;
        xword_t      b;
        xword_t      imm;
        xword_t      v;
        logic        we;
        retire_rec_t r;
        for (i = 0; i < prog_len; i++) begin
            stalls[i] = 0;
        end
        // A load-use bubble holds both the user in decode and its follower in fetch
        for (i = 1; i < prog_len; i++) begin
            if (prog[i-1].opcode == LOAD && prog[i-1].rd != '0
                && reads_reg(prog[i], prog[i-1].rd)) begin
                stalls[i]++;
                if (i + 1 < prog_len) begin
                    stalls[i+1]++;
                end
            end
        end
        for (i = 0; i < prog_len; i++) begin
            w    = prog[i];
            a    = ref_regs[w.rs1];
            b    = ref_regs[w.field[2:0]];
            imm  = {{(`PIPE_XLEN-6){w.field[5]}}, w.field};
            addr = (a + imm) % `PIPE_DMEM_DEPTH;
            v    = '0;
            we   = 1'b0;
            case (w.opcode)
                ADD: begin
                    v  = a + b;
                    we = 1'b1;
                end
                SUB: begin
                    v  = a - b;
                    we = 1'b1;
                end
                ADDI: begin
                    v  = a + imm;
                    we = 1'b1;
                end
                LOAD: begin
                    v  = ref_dmem[addr];
                    we = 1'b1;
                end
                STORE:   ref_dmem[addr] = b;
                default: ;
            endcase
            if (we && w.rd != '0) begin
                ref_regs[w.rd] = v;
            end
            r.tag          = next_tag;
            r.pc           = pc_t'(i);
            r.stall_cycles = 4'(stalls[i]);
            r.latency      = cnt_t'(5 + stalls[i]);
            r.we           = we;
            r.rd           = we ? w.rd : '0;
            r.value        = v;
            exp_q.push_back(r);
            halt_q.push_back(w.opcode == HALT);
            next_tag = next_tag + 1'b1;
        end
    endfunction

    task automatic put_instr(input opcode_t op, input int rd, input int rs1, input int field);
        prog[prog_len].opcode = op;
        prog[prog_len].rd     = reg_idx_t'(rd);
        prog[prog_len].rs1    = reg_idx_t'(rs1);
        prog[prog_len].field  = field[5:0];
        prog_len++;
    endtask

    task automatic load_program();
        int i;
        for (i = 0; i < prog_len; i++) begin
            @(negedge clk);
            imem_we    = 1'b1;
            imem_addr  = pc_t'(i);
            imem_wdata = prog[i];
        end
        @(negedge clk);
        imem_we = 1'b0;
    endtask

    task automatic run_program();
        int n;
        int done_before;
        int limit;
        load_program();
        predict();
        done_before = done_cnt;
        limit       = 4 * prog_len + 40;
        @(negedge clk);
        run = 1'b1;
        n   = 0;
        while (done_cnt == done_before) begin
            @(posedge clk);
            n++;
            if (n > limit) begin
                report_error("timeout waiting for done after starting the program");
            end
        end
        @(negedge clk);
        run = 1'b0;
        // Trailing cycles let the compare process catch any stray record or done
        repeat (4) @(posedge clk);
        prog_len = 0;
    endtask

    task automatic check_record(input retire_rec_t got, input retire_rec_t want);
        assert (got.tag == want.tag)
            else report_mismatch("retire.tag", got.tag, want.tag);
        assert (got.pc == want.pc)
            else report_mismatch("retire.pc", got.pc, want.pc);
        assert (got.stall_cycles == want.stall_cycles)
            else report_mismatch("retire.stall_cycles", got.stall_cycles, want.stall_cycles);
        assert (got.latency == want.latency)
            else report_mismatch("retire.latency", got.latency, want.latency);
        assert (got.we == want.we)
            else report_mismatch("retire.we", got.we, want.we);
        assert (got.rd == want.rd)
            else report_mismatch("retire.rd", got.rd, want.rd);
        assert (got.value == want.value)
            else report_mismatch("retire.value", got.value, want.value);
    endtask

    // Outputs are registered on the rising edge, so the falling edge sees them settled
    always @(negedge clk) begin
        if (retire_valid) begin
            assert (exp_q.size() > 0)
                else report_error("completion record arrived with none outstanding");
            exp_rec  = exp_q.pop_front();
            exp_halt = halt_q.pop_front();
            check_record(retire, exp_rec);
            assert (done == exp_halt) else report_mismatch("done", done, exp_halt);
        end else begin
            assert (!done) else report_error("done pulsed without a completion record");
        end
        if (done) begin
            done_cnt++;
        end
    end

    initial begin
        int i;
        seed       = 40004;
        rst        = 1'b1;
        run        = 1'b0;
        imem_we    = 1'b0;
        imem_addr  = '0;
        imem_wdata = '0;
        prog_len   = 0;
        next_tag   = '0;
        for (i = 0; i < `PIPE_NREGS; i++) begin
            ref_regs[i] = '0;
        end
        for (i = 0; i < `PIPE_DMEM_DEPTH; i++) begin
            ref_dmem[i] = '0;
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Idle with run low
        repeat (20) begin
            @(negedge clk);
            assert (!retire_valid) else report_error("retire_valid rose while run was low");
        end

        // Dependent ALU chain, all through forwarding
        put_instr(ADDI, 1, 0, 5);
        put_instr(ADDI, 2, 1, 3);
        put_instr(ADD, 3, 1, 2);
        put_instr(SUB, 4, 3, 1);
        put_instr(ADDI, 4, 4, -2);
        put_instr(ADD, 5, 4, 3);
        put_instr(SUB, 6, 0, 5);
        put_instr(HALT, 0, 0, 0);
        run_program();

        // Memory traffic and load-use
        put_instr(ADDI, 1, 0, 9);
        put_instr(ADDI, 2, 0, -7);
        put_instr(STORE, 0, 0, 1);
        put_instr(STORE, 0, 1, 2);
        put_instr(LOAD, 3, 0, 1);
        put_instr(ADD, 4, 3, 3);
        put_instr(LOAD, 5, 1, 2);
        put_instr(ADDI, 6, 1, 1);
        put_instr(SUB, 7, 5, 6);
        put_instr(HALT, 0, 0, 0);
        run_program();

        // r0 writes retire but never stick
        put_instr(ADDI, 0, 1, 7);
        put_instr(ADD, 2, 0, 0);
        put_instr(LOAD, 0, 0, 1);
        put_instr(ADDI, 3, 0, 4);
        put_instr(HALT, 0, 0, 0);
        run_program();

        // Random program, opcodes NOP through STORE
        for (i = 0; i < 39; i++) begin
            put_instr(opcode_t'($unsigned($random(seed)) % 6),
                      $unsigned($random(seed)) % 8,
                      $unsigned($random(seed)) % 8,
                      $unsigned($random(seed)) % 64);
        end
        put_instr(HALT, 0, 0, 0);
        run_program();

        $display("All tests passed");
        $finish;
    end

endmodule

/* src/pipe_top.sv */
`timescale 1ns/1ns

module pipe_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   run,
    input  logic                   imem_we,
    input  isa_pkg::pc_t           imem_addr,
    input  isa_pkg::instr_t        imem_wdata,
    output logic                   retire_valid,
    output trace_pkg::retire_rec_t retire,
    output logic                   done
);
    import isa_pkg::*;
    import trace_pkg::*;

    logic      fetch_fire;
    pc_t       fetch_pc;
    instr_t    fetch_word;
    logic      fetch_word_valid;
    logic      stall;
    dec_op_t   dec_op;
    dec_op_t   ex_op;
    logic      rf_we;
    reg_idx_t  rf_waddr;
    xword_t    rf_wdata;
    wb_event_t wb_event;

    instr_fetch u_fetch (
        .clk              (clk),
        .rst              (rst),
        .run              (run),
        .imem_we          (imem_we),
        .imem_addr        (imem_addr),
        .imem_wdata       (imem_wdata),
        .stall            (stall),
        .fetch_fire       (fetch_fire),
        .fetch_pc         (fetch_pc),
        .fetch_word       (fetch_word),
        .fetch_word_valid (fetch_word_valid)
    );

    instr_decode u_decode (
        .clk              (clk),
        .rst              (rst),
        .fetch_word       (fetch_word),
        .fetch_word_valid (fetch_word_valid),
        .fetch_pc         (fetch_pc),
        .ex_op            (ex_op),
        .rf_we            (rf_we),
        .rf_waddr         (rf_waddr),
        .rf_wdata         (rf_wdata),
        .stall            (stall),
        .dec_op           (dec_op)
    );

    exec_mem_wb u_exec (
        .clk      (clk),
        .rst      (rst),
        .dec_op   (dec_op),
        .ex_op    (ex_op),
        .rf_we    (rf_we),
        .rf_waddr (rf_waddr),
        .rf_wdata (rf_wdata),
        .wb_event (wb_event)
    );

    pipeline_tracker u_tracker (
        .clk          (clk),
        .rst          (rst),
        .fetch_fire   (fetch_fire),
        .fetch_pc     (fetch_pc),
        .stall        (stall),
        .wb_event     (wb_event),
        .retire_valid (retire_valid),
        .retire       (retire),
        .done         (done)
    );

endmodule

/* src/pipeline_tracker.sv */
`timescale 1ns/1ns

module pipeline_tracker (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   fetch_fire,
    input  isa_pkg::pc_t           fetch_pc,
    input  logic                   stall,
    input  trace_pkg::wb_event_t   wb_event,
    output logic                   retire_valid,
    output trace_pkg::retire_rec_t retire,
    output logic                   done
);
    import isa_pkg::*;
    import trace_pkg::*;

    typedef struct packed {
        logic       valid;
        tag_t       tag;
        pc_t        pc;
        cnt_t       fetch_cyc;
        logic [3:0] stalls;
    } slot_t;

    slot_t f_q;
    slot_t d_q;
    slot_t e_q;
    slot_t m_q;
    slot_t w_q;
    slot_t f_new;
    tag_t  tag_cnt;
    cnt_t  cyc;

    always_comb begin
        f_new           = '0;
        f_new.valid     = fetch_fire;
        f_new.tag       = tag_cnt;
        f_new.pc        = fetch_pc;
        f_new.fetch_cyc = cyc;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            f_q     <= '0;
            d_q     <= '0;
            e_q     <= '0;
            m_q     <= '0;
            w_q     <= '0;
            tag_cnt <= '0;
            cyc     <= '0;
        end else begin
            cyc <= cyc + 1'b1;
            if (fetch_fire) begin
                tag_cnt <= tag_cnt + 1'b1;
            end
            if (stall) begin
                // Both held slots lose a cycle, execute gets a bubble
                if (f_q.valid) begin
                    f_q.stalls <= f_q.stalls + 1'b1;
                end
                d_q.stalls <= d_q.stalls + 1'b1;
                e_q        <= '0;
            end else begin
                f_q <= f_new;
                d_q <= f_q;
                e_q <= d_q;
            end
            m_q <= e_q;
            w_q <= m_q;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            retire_valid <= 1'b0;
            done         <= 1'b0;
        end else begin
            retire_valid <= wb_event.valid;
            done         <= wb_event.valid & wb_event.is_halt;
        end
    end

    always_ff @(posedge clk) begin
        if (wb_event.valid) begin
            retire.tag          <= w_q.tag;
            retire.pc           <= w_q.pc;
            retire.stall_cycles <= w_q.stalls;
            retire.latency      <= cyc - w_q.fetch_cyc;
            retire.we           <= wb_event.we;
            retire.rd           <= wb_event.rd;
            retire.value        <= wb_event.value;
        end
    end

    // Slot model must stay in step with the real pipeline
    a_wb_slot_match: assert property (
        @(posedge clk) disable iff (rst) wb_event.valid == w_q.valid
    );

endmodule

/* src/exec_mem_wb.sv */
`timescale 1ns/1ns

`include "pipe_config.svh"

module exec_mem_wb (
    input  logic                  clk,
    input  logic                  rst,
    input  isa_pkg::dec_op_t      dec_op,
    output isa_pkg::dec_op_t      ex_op,
    output logic                  rf_we,
    output isa_pkg::reg_idx_t     rf_waddr,
    output isa_pkg::xword_t       rf_wdata,
    output trace_pkg::wb_event_t  wb_event
);
    import isa_pkg::*;
    import trace_pkg::*;

    localparam int DADDR_W = $clog2(`PIPE_DMEM_DEPTH);

    typedef struct packed {
        logic     valid;
        opcode_t  opcode;
        logic     we;
        reg_idx_t rd;
        xword_t   result;
        xword_t   store_data;
    } mem_reg_t;

    dec_op_t   ex_q;
    mem_reg_t  mem_q;
    wb_event_t wb_q;
    xword_t    dmem [`PIPE_DMEM_DEPTH];
    xword_t    op_a;
    xword_t    op_b;
    xword_t    alu_res;
    xword_t    mem_value;
    logic [DADDR_W-1:0] daddr;

    // Forward from memory first, then writeback, then the decode read
    function automatic xword_t fwd(input reg_idx_t idx, input xword_t rf_val);
        if (idx != '0 && mem_q.valid && mem_q.we && mem_q.rd == idx) begin
            return mem_q.result;
        end
        if (idx != '0 && wb_q.valid && wb_q.we && wb_q.rd == idx) begin
            return wb_q.value;
        end
        return rf_val;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_q.valid <= 1'b0;
        end else begin
            ex_q <= dec_op;
        end
    end

    always_comb begin
        op_a = fwd(ex_q.rs1, ex_q.rs1_val);
        op_b = fwd(ex_q.rs2, ex_q.rs2_val);
    end

    always_comb begin
        case (ex_q.opcode)
            ADD:                 alu_res = op_a + op_b;
            SUB:                 alu_res = op_a - op_b;
            ADDI, LOAD, STORE:   alu_res = op_a + ex_q.imm;
            default:             alu_res = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_q.valid <= 1'b0;
        end else begin
            mem_q.valid      <= ex_q.valid;
            mem_q.opcode     <= ex_q.opcode;
            mem_q.we         <= ex_q.we;
            mem_q.rd         <= ex_q.rd;
            mem_q.result     <= alu_res;
            mem_q.store_data <= op_b;
        end
    end

    // Address wraps at the data memory depth
    assign daddr     = mem_q.result[DADDR_W-1:0];
    assign mem_value = (mem_q.opcode == LOAD) ? dmem[daddr] : mem_q.result;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `PIPE_DMEM_DEPTH; i++) begin
                dmem[i] <= '0;
            end
        end else if (mem_q.valid && mem_q.opcode == STORE) begin
            dmem[daddr] <= mem_q.store_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_q <= '0;
        end else begin
            wb_q.valid   <= mem_q.valid;
            wb_q.is_halt <= mem_q.valid && mem_q.opcode == HALT;
            wb_q.we      <= mem_q.we;
            // Non-writing instructions report rd and value as zero
            wb_q.rd      <= mem_q.we ? mem_q.rd : '0;
            wb_q.value   <= mem_q.we ? mem_value : '0;
        end
    end

    assign ex_op    = ex_q;
    assign rf_we    = wb_q.valid & wb_q.we;
    assign rf_waddr = wb_q.rd;
    assign rf_wdata = wb_q.value;
    assign wb_event = wb_q;

endmodule

/* src/instr_decode.sv */
`timescale 1ns/1ns

`include "pipe_config.svh"

module instr_decode (
    input  logic              clk,
    input  logic              rst,
    input  isa_pkg::instr_t   fetch_word,
    input  logic              fetch_word_valid,
    input  isa_pkg::pc_t      fetch_pc,
    input  isa_pkg::dec_op_t  ex_op,
    input  logic              rf_we,
    input  isa_pkg::reg_idx_t rf_waddr,
    input  isa_pkg::xword_t   rf_wdata,
    output logic              stall,
    output isa_pkg::dec_op_t  dec_op
);
    import isa_pkg::*;

    xword_t  rf [`PIPE_NREGS];
    pc_t     word_pc_q;
    dec_op_t dec_n;
    dec_op_t dec_q;
    logic    reads_rs1;
    logic    reads_rs2;

    // Register read with bypass of the write happening this cycle
    function automatic xword_t read_reg(input reg_idx_t idx);
        if (idx == '0) begin
            return '0;
        end
        if (rf_we && rf_waddr == idx) begin
            return rf_wdata;
        end
        return rf[idx];
    endfunction

    // fetch_pc is the address issued this cycle, so the PC of the word
    // arriving in the boundary register is one step behind it
    always_ff @(posedge clk) begin
        if (!stall) begin
            word_pc_q <= fetch_pc;
        end
    end

    always_comb begin
        dec_n        = '0;
        dec_n.valid  = fetch_word_valid;
        dec_n.opcode = fetch_word.opcode;
        dec_n.rd     = fetch_word.rd;
        dec_n.rs1    = fetch_word.rs1;
        dec_n.rs2    = fetch_word.field[REG_W-1:0];
        dec_n.imm    = {{(`PIPE_XLEN-6){fetch_word.field[5]}}, fetch_word.field};
        dec_n.pc     = word_pc_q;
        case (fetch_word.opcode)
            ADD, SUB, ADDI, LOAD: dec_n.we = 1'b1;
            default:              dec_n.we = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dec_q.valid <= 1'b0;
        end else if (!stall) begin
            dec_q <= dec_n;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `PIPE_NREGS; i++) begin
                rf[i] <= '0;
            end
        end else if (rf_we && rf_waddr != '0) begin
            rf[rf_waddr] <= rf_wdata;
        end
    end

    assign reads_rs1 = dec_q.opcode inside {ADD, SUB, ADDI, LOAD, STORE};
    assign reads_rs2 = dec_q.opcode inside {ADD, SUB, STORE};

    // Load-use: the LOAD result is only forwardable once it reaches writeback
    assign stall = dec_q.valid && ex_op.valid && ex_op.opcode == LOAD
                   && ex_op.rd != '0
                   && ((reads_rs1 && dec_q.rs1 == ex_op.rd)
                       || (reads_rs2 && dec_q.rs2 == ex_op.rd));

    always_comb begin
        dec_op         = dec_q;
        dec_op.valid   = dec_q.valid & ~stall;
        dec_op.rs1_val = read_reg(dec_q.rs1);
        dec_op.rs2_val = read_reg(dec_q.rs2);
    end

    // The held instruction sees the LOAD move to memory a cycle later
    a_stall_one_cycle: assert property (
        @(posedge clk) disable iff (rst) stall |=> !stall
    );

endmodule

/* src/instr_fetch.sv */
`timescale 1ns/1ns

`include "pipe_config.svh"

module instr_fetch (
    input  logic             clk,
    input  logic             rst,
    input  logic             run,
    input  logic             imem_we,
    input  isa_pkg::pc_t     imem_addr,
    input  isa_pkg::instr_t  imem_wdata,
    input  logic             stall,
    output logic             fetch_fire,
    output isa_pkg::pc_t     fetch_pc,
    output isa_pkg::instr_t  fetch_word,
    output logic             fetch_word_valid
);
    import isa_pkg::*;

    instr_t imem [`PIPE_IMEM_DEPTH];
    instr_t cur_word;
    pc_t    pc;
    logic   run_q;
    logic   active;

    assign cur_word = imem[pc];

    // No fetch in the cycle run rises, the PC is being cleared then
    assign fetch_fire = active & run & run_q & ~stall;
    assign fetch_pc   = pc;

    always_ff @(posedge clk) begin
        if (imem_we) begin
            imem[imem_addr] <= imem_wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            run_q            <= 1'b0;
            active           <= 1'b0;
            pc               <= '0;
            fetch_word_valid <= 1'b0;
        end else begin
            run_q <= run;
            if (run && !run_q) begin
                pc     <= '0;
                active <= 1'b1;
            end else if (fetch_fire) begin
                pc <= pc + 1'b1;
                // Stop after HALT until the next run edge
                if (cur_word.opcode == HALT) begin
                    active <= 1'b0;
                end
            end
            if (!stall) begin
                fetch_word_valid <= fetch_fire;
            end
        end
    end

    // Boundary register toward decode, held during a stall
    always_ff @(posedge clk) begin
        if (fetch_fire) begin
            fetch_word <= cur_word;
        end
    end

    a_no_load_while_running: assert property (
        @(posedge clk) disable iff (rst) imem_we |-> !run
    );

endmodule

/* src/trace_pkg.sv */
`include "pipe_config.svh"

package trace_pkg;

    typedef logic [`PIPE_TAG_W-1:0] tag_t;
    typedef logic [`PIPE_CNT_W-1:0] cnt_t;

    // What leaves the writeback stage each cycle
    typedef struct packed {
        logic              valid;
        logic              is_halt;
        logic              we;
        isa_pkg::reg_idx_t rd;
        isa_pkg::xword_t   value;
    } wb_event_t;

    // One record per retired instruction
    typedef struct packed {
        tag_t              tag;
        isa_pkg::pc_t      pc;
        logic [3:0]        stall_cycles;
        cnt_t              latency;
        logic              we;
        isa_pkg::reg_idx_t rd;
        isa_pkg::xword_t   value;
    } retire_rec_t;

endpackage

/* src/isa_pkg.sv */
`include "pipe_config.svh"

package isa_pkg;

    localparam int PC_W  = $clog2(`PIPE_IMEM_DEPTH);
    localparam int REG_W = $clog2(`PIPE_NREGS);

    typedef logic [PC_W-1:0]       pc_t;
    typedef logic [REG_W-1:0]      reg_idx_t;
    typedef logic [`PIPE_XLEN-1:0] xword_t;

    typedef enum logic [3:0] {
        NOP   = 4'd0,
        ADD   = 4'd1,
        SUB   = 4'd2,
        ADDI  = 4'd3,
        LOAD  = 4'd4,
        STORE = 4'd5,
        HALT  = 4'd6
    } opcode_t;

    // 16-bit instruction word
    typedef struct packed {
        opcode_t    opcode;
        reg_idx_t   rd;
        reg_idx_t   rs1;
        logic [5:0] field;  // rs2 in the low bits, or a signed immediate
    } instr_t;

    typedef struct packed {
        logic     valid;
        opcode_t  opcode;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        xword_t   rs1_val;
        xword_t   rs2_val;
        xword_t   imm;
        logic     we;
        pc_t      pc;
    } dec_op_t;

endpackage

/* src/pipe_config.svh */
`ifndef PIPE_CONFIG_SVH
`define PIPE_CONFIG_SVH

// Datapath width in bits
`define PIPE_XLEN 16

// Architectural registers, r0 reads as zero
`define PIPE_NREGS 8

// Memory depths in words
`define PIPE_IMEM_DEPTH 64
`define PIPE_DMEM_DEPTH 16

// Tracker tag width, tags wrap at 2**PIPE_TAG_W
`define PIPE_TAG_W 3

// Cycle and latency counter width
`define PIPE_CNT_W 16

`endif
